// File: Makefile
SOURCES = $(wildcard hw/*.sv verification/*.sv)

.PHONY: all run clean

all: run

obj_dir/uartTb: uartSelfTest.f $(SOURCES)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module uartTb -f uartSelfTest.f -o uartTb

run: obj_dir/uartTb
	@out="$$(./obj_dir/uartTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: hw/baudTickGen.sv
module baudTickGen #(
	parameter int clkRate = 50000000,
	parameter int baudRate = 115200
) (
	input logic SysClk,
	input logic reset,
	output logic baudTick
);
	import uartPkg::*;

	// SysClk cycles per oversample tick
	localparam int divRatio = clkRate / (baudRate * oversample);
	localparam int cntWidth = (divRatio > 1) ? $clog2(divRatio) : 1;

	logic [cntWidth-1:0] tickCount;  // Counts down to zero, then reloads

	always_ff @(posedge SysClk) begin
		if (reset) begin
			tickCount <= cntWidth'(divRatio - 1);
			baudTick <= 1'b0;
		end else if (tickCount == '0) begin
			tickCount <= cntWidth'(divRatio - 1);  // Reload
			baudTick <= 1'b1;                      // One pulse per reload
		end else begin
			tickCount <= tickCount - 1'b1;
			baudTick <= 1'b0;
		end
	end

	// Clock too slow for the requested baud rate gives a zero ratio
	divRatioValid: assert property (@(posedge SysClk) divRatio >= 1)
		else $error("baudTickGen divide ratio below 1");

endmodule

// File: hw/rxFifo.sv
module rxFifo #(
	parameter int dataBits = 8,
	parameter int fifoDepth = 8
) (
	input logic SysClk,
	input logic reset,
	input logic rxDataRdy,
	input logic testMode,
	input logic popData,
	input logic [dataBits-1:0] rxByte,
	output logic [dataBits-1:0] dataOut,
	output logic fifoEmpty,
	output logic fifoFull,
	output logic fifoOverflow
);

	localparam int addrBits = $clog2(fifoDepth);

	logic [dataBits-1:0] fifoMem [fifoDepth];
	logic [addrBits:0] wrPtr;  // Extra MSB tells full from empty
	logic [addrBits:0] rdPtr;
	logic pushReq;
	logic doPush;
	logic doPop;

	assign pushReq = rxDataRdy && !testMode;  // Loopback bytes stay out
	assign doPush = pushReq && !fifoFull;     // Dropped when full
	assign doPop = popData && !fifoEmpty;

	assign fifoEmpty = (wrPtr == rdPtr);
	// Same slot one lap apart
	assign fifoFull = (wrPtr[addrBits] != rdPtr[addrBits]) &&
		(wrPtr[addrBits-1:0] == rdPtr[addrBits-1:0]);

	assign dataOut = fifoMem[rdPtr[addrBits-1:0]];  // Fall-through head

	always_ff @(posedge SysClk) begin
		if (doPush)
			fifoMem[wrPtr[addrBits-1:0]] <= rxByte;
	end

	//********************
	// Pointers and flags
	//********************
	always_ff @(posedge SysClk) begin
		if (reset) begin
			wrPtr <= '0;
			rdPtr <= '0;
			fifoOverflow <= 1'b0;
		end else begin
			if (doPush)
				wrPtr <= wrPtr + 1'b1;
			if (doPop)
				rdPtr <= rdPtr + 1'b1;
			if (pushReq && fifoFull)
				fifoOverflow <= 1'b1;  // Sticky until reset
		end
	end

	fifoFlagsExclusive: assert property (@(posedge SysClk) disable iff (reset)
		!(fifoFull && fifoEmpty))
		else $error("fifoFull and fifoEmpty both high");

endmodule

// File: hw/selfTestCtrl.sv
module selfTestCtrl #(
	parameter int dataBits = 8
) (
	input logic SysClk,
	input logic reset,
	input logic bistStart,
	input logic txBusy,
	input logic rxDataRdy,
	input logic [dataBits-1:0] txData,
	input logic [dataBits-1:0] rxByte,
	output logic testMode,
	output logic testStart,
	output logic bistBusy,
	output logic bistError,
	output logic [dataBits-1:0] testData
);
	import uartPkg::*;

	testState_t testState;
	logic [dataBits-1:0] pattern;   // Taken from txData at start
	logic [dataBits-1:0] echoByte;  // Byte returned over the loopback
	logic byteIndex;                // 0 sends pattern, 1 sends its inverse
	logic mismatch;                 // Accumulated over both bytes

	// Byte in flight, also the expected echo
	assign testData = byteIndex ? ~pattern : pattern;

	//********************
	// Self test sequencer
	//********************
	always_ff @(posedge SysClk) begin
		if (reset) begin
			testState <= testIdle;
			testMode <= 1'b0;
			testStart <= 1'b0;
			bistBusy <= 1'b0;
			bistError <= 1'b0;
			byteIndex <= 1'b0;
			mismatch <= 1'b0;
		end else begin
			testStart <= 1'b0;  // Single-cycle strobe
			unique case (testState)
				testIdle: begin
					if (bistStart) begin
						pattern <= txData;
						byteIndex <= 1'b0;
						mismatch <= 1'b0;
						bistError <= 1'b0;  // Previous result cleared
						bistBusy <= 1'b1;
						testMode <= 1'b1;   // Take over transmitter, close loop
						testState <= testSend;
					end
				end
				testSend: begin
					// Previous frame must finish its stop bit first
					if (!txBusy) begin
						testStart <= 1'b1;
						testState <= testWait;
					end
				end
				testWait: begin
					if (rxDataRdy) begin
						echoByte <= rxByte;
						testState <= testCompare;
					end
				end
				testCompare: begin
					if (echoByte != testData)
						mismatch <= 1'b1;
					if (byteIndex)
						testState <= testDone;
					else begin
						byteIndex <= 1'b1;  // Now the inverse
						testState <= testSend;
					end
				end
				testDone: begin
					if (!txBusy) begin  // Last stop bit done
						bistBusy <= 1'b0;
						bistError <= mismatch;
						testMode <= 1'b0;
						testState <= testIdle;
					end
				end
				default: testState <= testIdle;
			endcase
		end
	end

endmodule

// File: hw/uartPkg.sv
package uartPkg;

	//********************
	// Oversampling
	//********************
	localparam int oversample = 16;  // Baud ticks per bit
	localparam int sampleMid = 7;    // Tick index for mid-bit sampling

	//********************
	// State encodings
	//********************

	// Receiver
	typedef enum logic [1:0] {
		rxIdle,
		rxStartBit,
		rxDataBit,
		rxStopBit
	} rxState_t;

	// Transmitter
	typedef enum logic [1:0] {
		txIdle,
		txStartBit,
		txDataBit,
		txStopBit
	} txState_t;

	// Self test sequencer
	typedef enum logic [2:0] {
		testIdle,
		testSend,
		testWait,
		testCompare,
		testDone
	} testState_t;

endpackage

// File: hw/uartReceiver.sv
module uartReceiver #(
	parameter int dataBits = 8,
	parameter int stopBits = 1
) (
	input logic SysClk,
	input logic reset,
	input logic baudTick,
	input logic rxIn,
	output logic [dataBits-1:0] rxByte,
	output logic rxDataRdy,
	output logic rxError
);
	import uartPkg::*;

	localparam int tickWidth = $clog2(oversample);
	localparam int bitWidth = $clog2(dataBits + 1);

	rxState_t rxState;
	logic rxMeta;                     // First synchronizer stage
	logic rxSync;                     // Safe to use from here on
	logic [tickWidth-1:0] tickCount;  // Ticks within the current bit
	logic [bitWidth-1:0] bitCount;    // Data bits, then reused for stop bits
	logic [dataBits-1:0] rxShift;     // LSB arrives first
	logic lastTick;

	// Mid-bit point of a data or stop bit, one bit time after the previous one
	assign lastTick = (tickCount == tickWidth'(oversample - 1));

	// Line idles high
	always_ff @(posedge SysClk) begin
		if (reset) begin
			rxMeta <= 1'b1;
			rxSync <= 1'b1;
		end else begin
			rxMeta <= rxIn;
			rxSync <= rxMeta;
		end
	end

	//********************
	// Receive FSM
	//********************
	always_ff @(posedge SysClk) begin
		if (reset) begin
			rxState <= rxIdle;
			tickCount <= '0;
			bitCount <= '0;
			rxDataRdy <= 1'b0;
			rxError <= 1'b0;
		end else begin
			rxDataRdy <= 1'b0;  // Strobes last one cycle
			rxError <= 1'b0;
			if (baudTick) begin
				unique case (rxState)
					rxIdle: begin
						if (!rxSync) begin  // Possible start edge
							rxState <= rxStartBit;
							tickCount <= '0;
						end
					end
					rxStartBit: begin
						if (tickCount == tickWidth'(sampleMid)) begin
							tickCount <= '0;
							bitCount <= '0;
							// High at mid-bit means a glitch
							rxState <= rxSync ? rxIdle : rxDataBit;
						end else
							tickCount <= tickCount + 1'b1;
					end
					rxDataBit: begin
						if (lastTick) begin
							tickCount <= '0;
							rxShift <= {rxSync, rxShift[dataBits-1:1]};
							if (bitCount == bitWidth'(dataBits - 1)) begin
								bitCount <= '0;
								rxState <= rxStopBit;
							end else
								bitCount <= bitCount + 1'b1;
						end else
							tickCount <= tickCount + 1'b1;
					end
					rxStopBit: begin
						if (lastTick) begin
							tickCount <= '0;
							if (!rxSync) begin  // Framing error, byte discarded
								rxError <= 1'b1;
								rxState <= rxIdle;
							end else if (bitCount == bitWidth'(stopBits - 1)) begin
								rxByte <= rxShift;
								rxDataRdy <= 1'b1;
								rxState <= rxIdle;
							end else
								bitCount <= bitCount + 1'b1;  // Second stop bit
						end else
							tickCount <= tickCount + 1'b1;
					end
					default: rxState <= rxIdle;
				endcase
			end
		end
	end

	// A frame ends either good or bad, never both
	rxOutcomeExclusive: assert property (@(posedge SysClk) disable iff (reset)
		!(rxDataRdy && rxError))
		else $error("rxDataRdy and rxError in the same cycle");

endmodule

// File: hw/uartTop.sv
module uartTop #(
	parameter int clkRate = 50000000,
	parameter int baudRate = 115200,
	parameter int dataBits = 8,
	parameter int stopBits = 1,
	parameter int fifoDepth = 8
) (
	input logic SysClk,
	input logic reset,
	input logic rx,
	input logic cts,
	input logic [dataBits-1:0] txData,
	input logic txStart,
	input logic bistStart,
	input logic popData,
	output logic tx,
	output logic txBusy,
	output logic [dataBits-1:0] dataOut,
	output logic fifoEmpty,
	output logic fifoFull,
	output logic fifoOverflow,
	output logic rxError,
	output logic bistBusy,
	output logic bistError
);

	logic baudTick;               // 16x baud enable
	logic rxIn;                   // Receiver serial input after loopback mux
	logic txOut;                  // Transmitter serial output
	logic [dataBits-1:0] rxByte;
	logic rxDataRdy;
	logic testMode;               // Self test owns the transmitter
	logic testStart;
	logic [dataBits-1:0] testData;
	logic txStartMux;
	logic [dataBits-1:0] txDataMux;

	//********************
	// Loopback muxes
	//********************
	assign rxIn = testMode ? txOut : rx;
	assign tx = testMode ? 1'b1 : txOut;  // Pin parked at mark level

	// Transmit source
	assign txStartMux = testMode ? testStart : txStart;
	assign txDataMux = testMode ? testData : txData;

	//********************
	// Instances
	//********************
	baudTickGen #(
		.clkRate(clkRate),
		.baudRate(baudRate)
	) baudGen0 (
		.SysClk,
		.reset,
		.baudTick
	);

	uartReceiver #(
		.dataBits(dataBits),
		.stopBits(stopBits)
	) receiver0 (
		.SysClk,
		.reset,
		.baudTick,
		.rxIn,
		.rxByte,
		.rxDataRdy,
		.rxError
	);

	uartTransmitter #(
		.dataBits(dataBits),
		.stopBits(stopBits)
	) transmitter0 (
		.SysClk,
		.reset,
		.baudTick,
		.txStart(txStartMux),
		.cts,
		.txData(txDataMux),
		.txOut,
		.txBusy
	);

	selfTestCtrl #(
		.dataBits(dataBits)
	) selfTest0 (
		.SysClk,
		.reset,
		.bistStart,
		.txBusy,
		.rxDataRdy,
		.txData,
		.rxByte,
		.testMode,
		.testStart,
		.bistBusy,
		.bistError,
		.testData
	);

	rxFifo #(
		.dataBits(dataBits),
		.fifoDepth(fifoDepth)
	) rxFifo0 (
		.SysClk,
		.reset,
		.rxDataRdy,      // Write strobe
		.testMode,       // Blocks writes during self test
		.popData,
		.rxByte,
		.dataOut,
		.fifoEmpty,
		.fifoFull,
		.fifoOverflow
	);

endmodule

// File: hw/uartTransmitter.sv
module uartTransmitter #(
	parameter int dataBits = 8,
	parameter int stopBits = 1
) (
	input logic SysClk,
	input logic reset,
	input logic baudTick,
	input logic txStart,
	input logic cts,
	input logic [dataBits-1:0] txData,
	output logic txOut,
	output logic txBusy
);
	import uartPkg::*;

	localparam int tickWidth = $clog2(oversample);
	localparam int bitWidth = $clog2(dataBits + 1);

	txState_t txState;
	logic txPending;                  // Accepted, waiting for next tick
	logic [tickWidth-1:0] tickCount;
	logic [bitWidth-1:0] bitCount;
	logic [dataBits-1:0] txShift;
	logic lastTick;

	assign lastTick = (tickCount == tickWidth'(oversample - 1));  // Bit ends

	always_ff @(posedge SysClk) begin
		if (reset) begin
			txState <= txIdle;
			txPending <= 1'b0;
			tickCount <= '0;
			bitCount <= '0;
			txOut <= 1'b1;
			txBusy <= 1'b0;
		end else begin
			unique case (txState)
				txIdle: begin
					if (txPending && baudTick) begin  // Start bit on first tick
						txPending <= 1'b0;
						txState <= txStartBit;
						tickCount <= '0;
						txOut <= 1'b0;
						txBusy <= 1'b1;
					end else if (!txPending && txStart && cts) begin
						txPending <= 1'b1;
						txShift <= txData;  // Latch payload
					end
				end
				txStartBit: begin
					if (baudTick) begin
						if (lastTick) begin
							tickCount <= '0;
							bitCount <= '0;
							txOut <= txShift[0];  // LSB first
							txShift <= txShift >> 1;
							txState <= txDataBit;
						end else
							tickCount <= tickCount + 1'b1;
					end
				end
				txDataBit: begin
					if (baudTick) begin
						if (lastTick) begin
							tickCount <= '0;
							if (bitCount == bitWidth'(dataBits - 1)) begin
								bitCount <= '0;
								txOut <= 1'b1;  // Stop level
								txState <= txStopBit;
							end else begin
								bitCount <= bitCount + 1'b1;
								txOut <= txShift[0];
								txShift <= txShift >> 1;
							end
						end else
							tickCount <= tickCount + 1'b1;
					end
				end
				txStopBit: begin
					if (baudTick) begin
						if (lastTick) begin
							tickCount <= '0;
							if (bitCount == bitWidth'(stopBits - 1)) begin
								txBusy <= 1'b0;  // End of last stop bit
								txState <= txIdle;
							end else
								bitCount <= bitCount + 1'b1;
						end else
							tickCount <= tickCount + 1'b1;
					end
				end
				default: txState <= txIdle;
			endcase
		end
	end

	// Line must rest at mark level between frames
	txIdleHigh: assert property (@(posedge SysClk) disable iff (reset) !txBusy |-> txOut)
		else $error("tx low while transmitter idle");

endmodule

// File: uartSelfTest.f
hw/uartPkg.sv
hw/baudTickGen.sv
hw/uartReceiver.sv
hw/uartTransmitter.sv
hw/selfTestCtrl.sv
hw/rxFifo.sv
hw/uartTop.sv
verification/uartChecker.sv
verification/uartTb.sv

// File: verification/uartChecker.sv
module uartChecker #(
	parameter int dataBits = 8,
	parameter int fifoDepth = 8,
	parameter int frameCycles = 320
) (
	input logic SysClk,
	input logic reset,
	input logic tx,
	input logic txBusy,
	input logic [dataBits-1:0] dataOut,
	input logic fifoEmpty,
	input logic fifoFull,
	input logic fifoOverflow,
	input logic rxError,
	input logic bistBusy,
	input logic bistError,
	input logic popData,
	input logic pushStrobe,               // Byte that should now be stored
	input logic [dataBits-1:0] pushByte,
	input logic framingStrobe,            // One bad stop bit was sent
	input logic frameStrobe,              // One transmit frame expected
	input logic flagCheck,                // Compare flags and counters now
	output int errorCount,
	output int checkCount,
	output int modelCount
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [dataBits-1:0] model [$];  // Expected FIFO contents, head first
	logic modelOverflow;
	int framesExpected;
	int framesSeen;
	int errorsExpected;
	int errorsSeen;
	int busyLength;                  // Cycles of the current txBusy pulse
	logic busyPrev;
	logic bistPrev;
	logic resetPrev;

	task automatic reportMismatch(input string what);
		errorCount++;
		$display("error at %0d ns: %s", $time, what);
	endtask

	task automatic compareValue(input string what, input logic [31:0] actual,
		input logic [31:0] expected);
		checkCount++;
		if (actual !== expected)
			reportMismatch($sformatf("%s is %0h, expected %0h", what, actual, expected));
	endtask

	task automatic compareBit(input string what, input logic actual, input logic expected);
		checkCount++;
		if (actual !== expected)
			reportMismatch($sformatf("%s is %b, expected %b", what, actual, expected));
	endtask

	// Flags follow from the model depth alone
	task automatic verifyFlags();
		compareBit("fifoEmpty", fifoEmpty, model.size() == 0);
		compareBit("fifoFull", fifoFull, model.size() == fifoDepth);
		compareBit("fifoOverflow", fifoOverflow, modelOverflow);
	endtask

	//********************
	// Monitor, mid-cycle
	//********************
	always @(negedge SysClk) begin
		if (reset) begin
			model.delete();
			modelOverflow = 1'b0;
			framesExpected = 0;
			framesSeen = 0;
			errorsExpected = 0;
			errorsSeen = 0;
			busyLength = 0;
			busyPrev = 1'b0;
			bistPrev = 1'b0;
		end else begin
			if (resetPrev) begin  // First cycle out of reset
				compareBit("tx after reset", tx, 1'b1);
				compareBit("txBusy after reset", txBusy, 1'b0);
				compareBit("bistBusy after reset", bistBusy, 1'b0);
				compareBit("bistError after reset", bistError, 1'b0);
				compareBit("rxError after reset", rxError, 1'b0);
				verifyFlags();
			end
			if (popData) begin
				if (model.size() > 0) begin
					compareValue("dataOut", 32'(dataOut), 32'(model[0]));
					compareBit("fifoEmpty at pop", fifoEmpty, 1'b0);
					void'(model.pop_front());
				end else
					compareBit("fifoEmpty at pop of empty FIFO", fifoEmpty, 1'b1);
			end
			if (pushStrobe) begin
				if (model.size() < fifoDepth)
					model.push_back(pushByte);
				else
					modelOverflow = 1'b1;  // Byte dropped
			end
			if (framingStrobe)
				errorsExpected++;
			if (frameStrobe)
				framesExpected++;
			if (rxError)
				errorsSeen++;
			if (!txBusy && tx !== 1'b1)
				reportMismatch("tx low while txBusy is low");
			if (txBusy && !busyPrev) begin  // New frame
				framesSeen++;
				busyLength = 0;
			end
			if (txBusy)
				busyLength++;
			if (!txBusy && busyPrev)
				compareValue("txBusy cycles", busyLength, frameCycles);
			busyPrev = txBusy;
			if (bistBusy && tx !== 1'b1)
				reportMismatch("tx pin left mark level during self test");
			if (!bistBusy && bistPrev) begin  // Self test just ended
				compareBit("bistError", bistError, 1'b0);
				verifyFlags();
			end
			bistPrev = bistBusy;
			if (flagCheck) begin
				verifyFlags();
				compareValue("framing errors", errorsSeen, errorsExpected);
				compareValue("transmit frames", framesSeen, framesExpected);
			end
		end
		resetPrev = reset;
		modelCount = model.size();
	end

endmodule

// File: verification/uartTb.sv
module uartTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clkRate = 3200000;
	localparam int baudRate = 100000;
	localparam int dataBits = 8;
	localparam int stopBits = 1;
	localparam int fifoDepth = 8;
	localparam int bitCycles = clkRate / baudRate;  // 16 ticks of 2 cycles
	localparam int frameCycles = bitCycles * (1 + dataBits + stopBits);
	localparam int numTests = 19;
	localparam int watchdogCycles = numTests * 400 + 2000;

	typedef enum logic [1:0] {loopTest, ctsTest, lineTest, bistTest} testKind_t;
	typedef struct packed {
		logic [7:0] data;
		testKind_t kind;
		logic goodStop;  // Line frames only
		logic pop;       // Drain FIFO afterwards
	} testEntry_t;

	testEntry_t stimTable [numTests];
	logic SysClk, reset, rx, cts, txStart, bistStart, popData;
	logic [dataBits-1:0] txData;
	logic tx, txBusy, fifoEmpty, fifoFull, fifoOverflow, rxError, bistBusy, bistError;
	logic [dataBits-1:0] dataOut;
	logic lineJoin;  // Line model joins tx to rx
	logic rxDrive;   // Line level when driven here
	logic pushStrobe, framingStrobe, frameStrobe, flagCheck;
	logic [dataBits-1:0] pushByte;
	int errorCount, checkCount, modelCount;
	int hangCount;

	assign rx = lineJoin ? tx : rxDrive;  // Serial line model

	uartTop #(
		.clkRate(clkRate),
		.baudRate(baudRate),
		.dataBits(dataBits),
		.stopBits(stopBits),
		.fifoDepth(fifoDepth)
	) dut0 (.*);

	uartChecker #(
		.dataBits(dataBits),
		.fifoDepth(fifoDepth),
		.frameCycles(frameCycles)
	) check0 (.*);

	initial begin
		SysClk = 1'b0;
		forever #5 SysClk = ~SysClk;
	end

	initial begin
		repeat (watchdogCycles) @(posedge SysClk);
		$display("Simulation timed out after %0d clock cycles", watchdogCycles);
		$display("FAIL: see errors above");
		$finish;
	end

	task automatic stepCycle();
		@(posedge SysClk);
		#1;  // Inputs change just after the edge
	endtask

	task automatic waitCycles(input int n);
		repeat (n) stepCycle();
	endtask

	task automatic awaitTxBusy(input logic level, input int limit);
		int waited;
		waited = 0;
		while (txBusy !== level && waited < limit) begin
			stepCycle();
			waited++;
		end
		if (txBusy !== level) begin
			hangCount++;
			$display("Timed out at %0d ns waiting for txBusy to go %0b", $time, level);
		end
	endtask

	task automatic awaitBistBusy(input logic level, input int limit);
		int waited;
		waited = 0;
		while (bistBusy !== level && waited < limit) begin
			stepCycle();
			waited++;
		end
		if (bistBusy !== level) begin
			hangCount++;
			$display("Timed out at %0d ns waiting for bistBusy to go %0b", $time, level);
		end
	endtask

	//********************
	// Checker strobes
	//********************
	task automatic modelPush(input logic [7:0] b);
		pushByte = b;
		pushStrobe = 1'b1;
		stepCycle();
		pushStrobe = 1'b0;
	endtask

	task automatic noteFramingError();
		framingStrobe = 1'b1;
		stepCycle();
		framingStrobe = 1'b0;
	endtask

	task automatic countFrames(input int n);
		frameStrobe = 1'b1;  // One per cycle
		waitCycles(n);
		frameStrobe = 1'b0;
	endtask

	task automatic checkFlagsNow();
		flagCheck = 1'b1;
		stepCycle();
		flagCheck = 1'b0;
	endtask

	//********************
	// Test kinds
	//********************
	task automatic loopbackByte(input logic [7:0] b);
		lineJoin = 1'b1;
		txData = b;
		txStart = 1'b1;
		stepCycle();
		txStart = 1'b0;
		awaitTxBusy(1'b1, 8);
		waitCycles(3 * bitCycles);
		txData = ~b;         // Strobe while busy, must not produce a frame
		txStart = 1'b1;
		stepCycle();
		txStart = 1'b0;
		awaitTxBusy(1'b0, frameCycles);
		waitCycles(bitCycles);
		modelPush(b);
		countFrames(1);
	endtask

	task automatic blockedStart(input logic [7:0] b);
		lineJoin = 1'b1;
		cts = 1'b0;
		txData = b;
		txStart = 1'b1;
		stepCycle();
		txStart = 1'b0;
		waitCycles(2 * bitCycles);  // Frame would have started by now
		cts = 1'b1;
	endtask

	task automatic sendLineFrame(input logic [7:0] b, input logic goodStop);
		int k;
		lineJoin = 1'b0;
		rxDrive = 1'b0;  // Start bit
		waitCycles(bitCycles);
		for (k = 0; k < dataBits; k++) begin
			rxDrive = b[k];  // LSB first
			waitCycles(bitCycles);
		end
		rxDrive = goodStop;
		waitCycles(bitCycles);
		rxDrive = 1'b1;
		waitCycles(bitCycles);  // Idle gap
		if (goodStop)
			modelPush(b);
		else
			noteFramingError();
	endtask

	task automatic selfTestByte(input logic [7:0] b);
		lineJoin = 1'b0;
		txData = b;
		bistStart = 1'b1;
		stepCycle();
		bistStart = 1'b0;
		awaitBistBusy(1'b1, 4);
		awaitBistBusy(1'b0, 3 * frameCycles);
		countFrames(2);  // Pattern and its inverse
	endtask

	task automatic drainFifo();
		int count;
		count = modelCount;
		popData = 1'b1;
		waitCycles(count + 1);  // Last pop hits an empty FIFO
		popData = 1'b0;
		checkFlagsNow();
	endtask

	task automatic buildTable(inout int seed);
		int i;
		stimTable[0] = '{8'h55, loopTest, 1'b1, 1'b0};
		stimTable[1] = '{8'hA3, loopTest, 1'b1, 1'b0};
		stimTable[2] = '{8'($random(seed)), loopTest, 1'b1, 1'b1};
		stimTable[3] = '{8'h3C, ctsTest, 1'b1, 1'b0};
		stimTable[4] = '{8'h81, lineTest, 1'b1, 1'b0};
		stimTable[5] = '{8'h7E, lineTest, 1'b0, 1'b0};  // Low stop bit
		stimTable[6] = '{8'h42, lineTest, 1'b1, 1'b1};
		stimTable[7] = '{8'h96, bistTest, 1'b1, 1'b0};
		// One byte more than the FIFO holds
		for (i = 8; i <= 8 + fifoDepth; i++)
			stimTable[i] = '{8'($random(seed)), lineTest, 1'b1, i == 8 + fifoDepth};
		stimTable[17] = '{8'h0F, bistTest, 1'b1, 1'b0};
		stimTable[18] = '{8'($random(seed)), loopTest, 1'b1, 1'b1};
	endtask

	//********************
	// Main sequence
	//********************
	initial begin
		int seed;
		int i;
		seed = 43751;
		reset = 1'b1;
		cts = 1'b1;
		txData = '0;
		txStart = 1'b0;
		bistStart = 1'b0;
		popData = 1'b0;
		lineJoin = 1'b0;
		rxDrive = 1'b1;  // Mark level
		pushStrobe = 1'b0;
		pushByte = '0;
		framingStrobe = 1'b0;
		frameStrobe = 1'b0;
		flagCheck = 1'b0;
		hangCount = 0;
		buildTable(seed);
		repeat (16) @(posedge SysClk);
		#1 reset = 1'b0;
		for (i = 0; i < numTests; i++) begin
			case (stimTable[i].kind)
				loopTest: loopbackByte(stimTable[i].data);
				ctsTest: blockedStart(stimTable[i].data);
				lineTest: sendLineFrame(stimTable[i].data, stimTable[i].goodStop);
				default: selfTestByte(stimTable[i].data);
			endcase
			checkFlagsNow();
			if (stimTable[i].pop)
				drainFifo();
		end
		waitCycles(bitCycles);
		$display("checks %0d, errors %0d, timeouts %0d", checkCount, errorCount, hangCount);
		if (errorCount == 0 && hangCount == 0 && checkCount > 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule
